// ==== src/video_pkg.sv ====
`default_nettype none

package video_pkg;

    // ========================================
    // pixel and frame-buffer widths
    // ========================================
    localparam int pixel_w  = 8;   // one colour channel
    localparam int rgb565_w = 16;  // frame-buffer word

    // RGB565 field positions
    localparam int red_msb   = 15;
    localparam int red_lsb   = 11;
    localparam int green_msb = 10;
    localparam int green_lsb = 5;
    localparam int blue_msb  = 4;
    localparam int blue_lsb  = 0;

    // ========================================
    // grayscale weights
    // ========================================
    // weights add up to 252, sum is shifted right by 8
    localparam logic [7:0] gray_wr = 8'd76;
    localparam logic [7:0] gray_wg = 8'd150;
    localparam logic [7:0] gray_wb = 8'd26;

    // ========================================
    // default 640x480 raster
    // ========================================
    localparam int def_h_active = 640;
    localparam int def_h_front  = 16;
    localparam int def_h_sync   = 96;
    localparam int def_h_back   = 48;

    localparam int def_v_active = 480;
    localparam int def_v_front  = 10;
    localparam int def_v_sync   = 2;
    localparam int def_v_back   = 33;

    // cycles from address to data at the frame buffer
    localparam int def_mem_rd_lat = 2;

endpackage

`default_nettype wire

// ==== src/control_pkg.sv ====
`default_nettype none

package control_pkg;

    // ========================================
    // remote-control key codes
    // ========================================
    typedef enum logic [7:0] {
        key_red    = 8'h01,
        key_gray   = 8'h0F,
        key_orig   = 8'h12,  // OK button
        key_thresh = 8'h13,
        key_up     = 8'h1A,
        key_down   = 8'h1E
    } key_code_e;

    // display modes, also the controller state
    typedef enum logic [1:0] {
        mode_orig   = 2'd0,
        mode_gray   = 2'd1,
        mode_thresh = 2'd2,
        mode_red    = 2'd3
    } display_mode_e;

    // ========================================
    // threshold adjustment
    // ========================================
    localparam logic [7:0] thr_reset = 8'd64;
    localparam logic [7:0] thr_step  = 8'd5;
    localparam logic [7:0] thr_min   = 8'd0;    // saturation floor
    localparam logic [7:0] thr_max   = 8'd255;  // saturation ceiling

    // red-object mask limits
    localparam logic [7:0] red_min = 8'hC0;
    localparam logic [7:0] gb_max  = 8'h60;  // green and blue stay below this

endpackage

`default_nettype wire

// ==== src/mode_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module mode_controller (
    input  logic                       clk_25_vga,
    input  logic                       rst_n_50m,
    input  logic [7:0]                 ir_code,
    input  logic                       ir_valid,
    output control_pkg::display_mode_e display_mode,
    output logic [7:0]                 threshold
);

    control_pkg::display_mode_e mode_next;
    logic [7:0]                 thr_next;
    logic [7:0]                 thr_up;
    logic [7:0]                 thr_dn;

    // saturating steps
    assign thr_up = (threshold > (control_pkg::thr_max - control_pkg::thr_step))
                    ? control_pkg::thr_max
                    : threshold + control_pkg::thr_step;
    assign thr_dn = (threshold < (control_pkg::thr_min + control_pkg::thr_step))
                    ? control_pkg::thr_min
                    : threshold - control_pkg::thr_step;

    // ========================================
    // key decode
    // ========================================
    always_comb begin
        mode_next = display_mode;
        thr_next  = threshold;
        if (ir_valid) begin
            case (ir_code)
                control_pkg::key_orig: begin
                    mode_next = control_pkg::mode_orig;
                end
                control_pkg::key_gray: begin
                    mode_next = control_pkg::mode_gray;
                end
                control_pkg::key_thresh: begin
                    mode_next = control_pkg::mode_thresh;
                end
                control_pkg::key_red: begin
                    mode_next = control_pkg::mode_red;
                end
                control_pkg::key_up: begin
                    thr_next = thr_up;
                end
                control_pkg::key_down: begin
                    thr_next = thr_dn;
                end
                default: begin
                    // unknown key, hold everything
                end
            endcase
        end
    end

    // ========================================
    // state and threshold registers
    // ========================================
    always_ff @(posedge clk_25_vga) begin
        if (!rst_n_50m) begin
            display_mode <= control_pkg::mode_orig;
            threshold    <= control_pkg::thr_reset;
        end else begin
            display_mode <= mode_next;
            threshold    <= thr_next;
        end
    end

endmodule

`default_nettype wire

// ==== src/raster_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module raster_counter #(
    parameter int h_active = video_pkg::def_h_active,
    parameter int h_front  = video_pkg::def_h_front,
    parameter int h_sync   = video_pkg::def_h_sync,
    parameter int h_back   = video_pkg::def_h_back,
    parameter int v_active = video_pkg::def_v_active,
    parameter int v_front  = video_pkg::def_v_front,
    parameter int v_sync   = video_pkg::def_v_sync,
    parameter int v_back   = video_pkg::def_v_back,
    parameter int addr_w   = 19
) (
    input  logic              clk_25_vga,
    input  logic              rst_n_50m,
    output logic [addr_w-1:0] pixel_addr,
    output logic              active_raw,
    output logic              hsync_raw,
    output logic              vsync_raw
);

    localparam int h_total  = h_active + h_front + h_sync + h_back;
    localparam int v_total  = v_active + v_front + v_sync + v_back;
    localparam int hs_start = h_active + h_front;  // sync follows the front porch
    localparam int vs_start = v_active + v_front;
    localparam int hcnt_w   = $clog2(h_total);
    localparam int vcnt_w   = $clog2(v_total);

    logic [hcnt_w-1:0] h_cnt;
    logic [vcnt_w-1:0] v_cnt;
    logic [addr_w-1:0] addr_cnt;  // address of the current active pixel
    logic              line_end;
    logic              frame_end;

    assign line_end  = (h_cnt == hcnt_w'(h_total - 1));
    assign frame_end = line_end && (v_cnt == vcnt_w'(v_total - 1));

    // ========================================
    // position counters
    // ========================================
    always_ff @(posedge clk_25_vga) begin
        if (!rst_n_50m) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (line_end) begin
            h_cnt <= '0;
            if (frame_end) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // running address, restarts every frame
    always_ff @(posedge clk_25_vga) begin
        if (!rst_n_50m) begin
            addr_cnt <= '0;
        end else if (frame_end) begin
            addr_cnt <= '0;
        end else if (active_raw) begin
            addr_cnt <= addr_cnt + 1'b1;
        end
    end

    // ========================================
    // decoded outputs
    // ========================================
    assign active_raw = (h_cnt < hcnt_w'(h_active)) && (v_cnt < vcnt_w'(v_active));

    // active low
    assign hsync_raw = !((h_cnt >= hcnt_w'(hs_start)) &&
                         (h_cnt <  hcnt_w'(hs_start + h_sync)));
    assign vsync_raw = !((v_cnt >= vcnt_w'(vs_start)) &&
                         (v_cnt <  vcnt_w'(vs_start + v_sync)));

    assign pixel_addr = active_raw ? addr_cnt : '0;  // zero in blanking

endmodule

`default_nettype wire

// ==== src/pixel_convert.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_convert (
    input  logic                             clk_25_vga,
    input  logic                             rst_n_50m,
    input  logic [video_pkg::rgb565_w-1:0]   pixel_data,
    output logic [video_pkg::pixel_w-1:0]    r,
    output logic [video_pkg::pixel_w-1:0]    g,
    output logic [video_pkg::pixel_w-1:0]    b,
    output logic [video_pkg::pixel_w-1:0]    gray
);

    // ones appended below each field
    localparam int red_pad   = video_pkg::pixel_w -
                               (video_pkg::red_msb - video_pkg::red_lsb + 1);
    localparam int green_pad = video_pkg::pixel_w -
                               (video_pkg::green_msb - video_pkg::green_lsb + 1);
    localparam int blue_pad  = video_pkg::pixel_w -
                               (video_pkg::blue_msb - video_pkg::blue_lsb + 1);

    logic [video_pkg::pixel_w-1:0]   r888;
    logic [video_pkg::pixel_w-1:0]   g888;
    logic [video_pkg::pixel_w-1:0]   b888;
    logic [2*video_pkg::pixel_w-1:0] gray_sum;  // max 255*252, no overflow

    // ========================================
    // RGB565 to RGB888
    // ========================================
    assign r888 = {pixel_data[video_pkg::red_msb:video_pkg::red_lsb], {red_pad{1'b1}}};
    assign g888 = {pixel_data[video_pkg::green_msb:video_pkg::green_lsb], {green_pad{1'b1}}};
    assign b888 = {pixel_data[video_pkg::blue_msb:video_pkg::blue_lsb], {blue_pad{1'b1}}};

    // weighted luma
    assign gray_sum = r888 * video_pkg::gray_wr
                    + g888 * video_pkg::gray_wg
                    + b888 * video_pkg::gray_wb;

    // ========================================
    // output register
    // ========================================
    always_ff @(posedge clk_25_vga) begin
        if (!rst_n_50m) begin
            r    <= '0;
            g    <= '0;
            b    <= '0;
            gray <= '0;
        end else begin
            r    <= r888;
            g    <= g888;
            b    <= b888;
            gray <= gray_sum[2*video_pkg::pixel_w-1:video_pkg::pixel_w];  // >> 8
        end
    end

endmodule

`default_nettype wire

// ==== src/display_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module display_mux #(
    parameter int mem_rd_lat = video_pkg::def_mem_rd_lat
) (
    input  logic                          clk_25_vga,
    input  logic                          rst_n_50m,
    input  control_pkg::display_mode_e    display_mode,
    input  logic [7:0]                    threshold,
    input  logic [video_pkg::pixel_w-1:0] r,
    input  logic [video_pkg::pixel_w-1:0] g,
    input  logic [video_pkg::pixel_w-1:0] b,
    input  logic [video_pkg::pixel_w-1:0] gray,
    input  logic                          active_raw,
    input  logic                          hsync_raw,
    input  logic                          vsync_raw,
    output logic [video_pkg::pixel_w-1:0] vga_r,
    output logic [video_pkg::pixel_w-1:0] vga_g,
    output logic [video_pkg::pixel_w-1:0] vga_b,
    output logic                          vga_hsync,
    output logic                          vga_vsync
);

    localparam int n_stages = mem_rd_lat + 1;  // memory read plus convert register

    localparam logic [video_pkg::pixel_w-1:0] ch_full = '1;

    logic [2:0]                    flag_dly [n_stages];  // {active, hsync, vsync}
    logic                          active_al;
    logic                          hsync_al;
    logic                          vsync_al;
    logic [video_pkg::pixel_w-1:0] sel_r;
    logic [video_pkg::pixel_w-1:0] sel_g;
    logic [video_pkg::pixel_w-1:0] sel_b;

    // ========================================
    // flag alignment
    // ========================================
    always_ff @(posedge clk_25_vga) begin
        if (!rst_n_50m) begin
            for (int i = 0; i < n_stages; i++) begin
                flag_dly[i] <= 3'b011;  // inactive, syncs high
            end
        end else begin
            flag_dly[0] <= {active_raw, hsync_raw, vsync_raw};
            for (int i = 1; i < n_stages; i++) begin
                flag_dly[i] <= flag_dly[i-1];
            end
        end
    end

    assign {active_al, hsync_al, vsync_al} = flag_dly[n_stages-1];

    // ========================================
    // per-mode colour select
    // ========================================
    always_comb begin
        sel_r = '0;
        sel_g = '0;
        sel_b = '0;
        if (active_al) begin
            case (display_mode)
                control_pkg::mode_orig: begin
                    sel_r = r;
                    sel_g = g;
                    sel_b = b;
                end
                control_pkg::mode_gray: begin
                    sel_r = gray;
                    sel_g = gray;
                    sel_b = gray;
                end
                control_pkg::mode_thresh: begin
                    if (gray >= threshold) begin
                        sel_r = ch_full;
                        sel_g = ch_full;
                        sel_b = ch_full;
                    end
                end
                control_pkg::mode_red: begin
                    if ((r >= control_pkg::red_min) &&
                        (g < control_pkg::gb_max) && (b < control_pkg::gb_max)) begin
                        sel_r = ch_full;  // mask shown in pure red
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_25_vga) begin
        if (!rst_n_50m) begin
            vga_r     <= '0;
            vga_g     <= '0;
            vga_b     <= '0;
            vga_hsync <= 1'b1;
            vga_vsync <= 1'b1;
        end else begin
            vga_r     <= sel_r;
            vga_g     <= sel_g;
            vga_b     <= sel_b;
            vga_hsync <= hsync_al;
            vga_vsync <= vsync_al;
        end
    end

endmodule

`default_nettype wire

// ==== src/cam_display_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cam_display_top #(
    parameter int h_active   = video_pkg::def_h_active,
    parameter int h_front    = video_pkg::def_h_front,
    parameter int h_sync     = video_pkg::def_h_sync,
    parameter int h_back     = video_pkg::def_h_back,
    parameter int v_active   = video_pkg::def_v_active,
    parameter int v_front    = video_pkg::def_v_front,
    parameter int v_sync     = video_pkg::def_v_sync,
    parameter int v_back     = video_pkg::def_v_back,
    parameter int addr_w     = 19,  // 640x480 fits in 19 bits
    parameter int mem_rd_lat = video_pkg::def_mem_rd_lat
) (
    input  logic                           clk_25_vga,
    input  logic                           rst_n_50m,
    input  logic [7:0]                     ir_code,
    input  logic                           ir_valid,
    input  logic [video_pkg::rgb565_w-1:0] pixel_data,  // from the frame buffer
    output logic [addr_w-1:0]              pixel_addr,
    output logic [video_pkg::pixel_w-1:0]  vga_r,
    output logic [video_pkg::pixel_w-1:0]  vga_g,
    output logic [video_pkg::pixel_w-1:0]  vga_b,
    output logic                           vga_hsync,
    output logic                           vga_vsync
);

    control_pkg::display_mode_e    display_mode;
    logic [7:0]                    threshold;
    logic                          active_raw;
    logic                          hsync_raw;
    logic                          vsync_raw;
    logic [video_pkg::pixel_w-1:0] r;
    logic [video_pkg::pixel_w-1:0] g;
    logic [video_pkg::pixel_w-1:0] b;
    logic [video_pkg::pixel_w-1:0] gray;

    // ========================================
    // control and raster
    // ========================================
    mode_controller mode_controller_inst (
        .clk_25_vga  (clk_25_vga),
        .rst_n_50m   (rst_n_50m),
        .ir_code     (ir_code),
        .ir_valid    (ir_valid),
        .display_mode(display_mode),
        .threshold   (threshold)
    );

    raster_counter #(
        .h_active(h_active),
        .h_front (h_front),
        .h_sync  (h_sync),
        .h_back  (h_back),
        .v_active(v_active),
        .v_front (v_front),
        .v_sync  (v_sync),
        .v_back  (v_back),
        .addr_w  (addr_w)
    ) raster_counter_inst (
        .clk_25_vga(clk_25_vga),
        .rst_n_50m (rst_n_50m),
        .pixel_addr(pixel_addr),
        .active_raw(active_raw),
        .hsync_raw (hsync_raw),
        .vsync_raw (vsync_raw)
    );

    // ========================================
    // pixel path
    // ========================================
    pixel_convert pixel_convert_inst (
        .clk_25_vga(clk_25_vga),
        .rst_n_50m (rst_n_50m),
        .pixel_data(pixel_data),
        .r         (r),
        .g         (g),
        .b         (b),
        .gray      (gray)
    );

    display_mux #(
        .mem_rd_lat(mem_rd_lat)
    ) display_mux_inst (
        .clk_25_vga  (clk_25_vga),
        .rst_n_50m   (rst_n_50m),
        .display_mode(display_mode),
        .threshold   (threshold),
        .r           (r),
        .g           (g),
        .b           (b),
        .gray        (gray),
        .active_raw  (active_raw),
        .hsync_raw   (hsync_raw),
        .vsync_raw   (vsync_raw),
        .vga_r       (vga_r),
        .vga_g       (vga_g),
        .vga_b       (vga_b),
        .vga_hsync   (vga_hsync),
        .vga_vsync   (vga_vsync)
    );

endmodule

`default_nettype wire

// ==== tb/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// ========================================
// reference model
// ========================================
// RGB565 fields padded with ones in the low bits
function automatic logic [7:0] red_of(input logic [15:0] word);
    return {word[15:11], 3'b111};
endfunction

function automatic logic [7:0] green_of(input logic [15:0] word);
    return {word[10:5], 2'b11};
endfunction

function automatic logic [7:0] blue_of(input logic [15:0] word);
    return {word[4:0], 3'b111};
endfunction

function automatic logic [7:0] gray_of(input logic [15:0] word);
    int sum;
    sum = int'(red_of(word)) * int'(video_pkg::gray_wr)
        + int'(green_of(word)) * int'(video_pkg::gray_wg)
        + int'(blue_of(word)) * int'(video_pkg::gray_wb);
    return 8'(sum >> 8);
endfunction

// key rules applied to the model state
task automatic apply_key(input logic [7:0] code);
    int t;
    t = int'(m_thr);
    case (code)
        control_pkg::key_orig:   m_mode = control_pkg::mode_orig;
        control_pkg::key_gray:   m_mode = control_pkg::mode_gray;
        control_pkg::key_thresh: m_mode = control_pkg::mode_thresh;
        control_pkg::key_red:    m_mode = control_pkg::mode_red;
        control_pkg::key_up: begin
            t = t + int'(control_pkg::thr_step);
            if (t > 255) t = 255;  // saturate high
        end
        control_pkg::key_down: begin
            t = t - int'(control_pkg::thr_step);
            if (t < 0) t = 0;
        end
        default: ;  // unknown codes change nothing
    endcase
    m_thr = 8'(t);
endtask

// ========================================
// compare tasks
// ========================================
task automatic check_pixel(input control_pkg::display_mode_e mode,
                           input logic [7:0] got_r, input logic [7:0] got_g,
                           input logic [7:0] got_b, input logic [7:0] exp_r,
                           input logic [7:0] exp_g, input logic [7:0] exp_b);
    n_checks++;
    if (got_r !== exp_r || got_g !== exp_g || got_b !== exp_b) begin
        pixel_errs++;
        $display("MISMATCH at %0t: %s pixel got %h/%h/%h expected %h/%h/%h", $time,
                 mode.name(), got_r, got_g, got_b, exp_r, exp_g, exp_b);
    end
endtask

task automatic check_sync(input logic got_hs, input logic got_vs,
                          input logic exp_hs, input logic exp_vs);
    n_checks++;
    if (got_hs !== exp_hs || got_vs !== exp_vs) begin
        sync_errs++;
        $display("MISMATCH at %0t: hsync/vsync got %b/%b expected %b/%b", $time,
                 got_hs, got_vs, exp_hs, exp_vs);
    end
endtask

// frame-buffer read address
task automatic check_addr(input logic [addr_w-1:0] got, input logic [addr_w-1:0] exp);
    n_checks++;
    if (got !== exp) begin
        addr_errs++;
        $display("MISMATCH at %0t: pixel_addr got %0d expected %0d", $time, got, exp);
    end
endtask

// threshold mode drives all channels white or black
task automatic check_mode_state(input logic [7:0] thr, input logic [7:0] gray,
                                input logic [7:0] got_r, input logic [7:0] got_g,
                                input logic [7:0] got_b);
    logic [7:0] lvl;
    lvl = (gray >= thr) ? 8'hFF : 8'h00;
    n_checks++;
    if (got_r !== lvl || got_g !== lvl || got_b !== lvl) begin
        thr_errs++;
        $display("MISMATCH at %0t: threshold %0d gray %0d got %h/%h/%h expected %h", $time,
                 thr, gray, got_r, got_g, got_b, lvl);
    end
endtask

// one output cycle against the expected pipeline entry
task automatic check_output(input logic [18:0] ent, input control_pkg::display_mode_e mode,
                            input logic [7:0] thr);
    logic [15:0] word;
    logic        hit;
    word = ent[15:0];
    check_sync(vga_hsync, vga_vsync, ent[17], ent[16]);
    if (!ent[18]) begin
        check_pixel(mode, vga_r, vga_g, vga_b, 8'h00, 8'h00, 8'h00);  // blanking
    end else begin
        case (mode)
            control_pkg::mode_orig: begin
                check_pixel(mode, vga_r, vga_g, vga_b,
                            red_of(word), green_of(word), blue_of(word));
            end
            control_pkg::mode_gray: begin
                check_pixel(mode, vga_r, vga_g, vga_b,
                            gray_of(word), gray_of(word), gray_of(word));
            end
            control_pkg::mode_thresh: begin
                check_mode_state(thr, gray_of(word), vga_r, vga_g, vga_b);
            end
            default: begin
                hit = (red_of(word) >= control_pkg::red_min) &&
                      (green_of(word) < control_pkg::gb_max) &&
                      (blue_of(word) < control_pkg::gb_max);
                check_pixel(mode, vga_r, vga_g, vga_b, hit ? 8'hFF : 8'h00, 8'h00, 8'h00);
            end
        endcase
    end
endtask

`endif

// ==== tb/tb_cam_display.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cam_display;

    // ========================================
    // small raster for simulation
    // ========================================
    localparam int h_active   = 16;
    localparam int h_front    = 2;
    localparam int h_sync     = 4;
    localparam int h_back     = 2;
    localparam int v_active   = 8;
    localparam int v_front    = 1;
    localparam int v_sync     = 2;
    localparam int v_back     = 1;
    localparam int addr_w     = 7;
    localparam int mem_rd_lat = 2;

    localparam int h_total      = h_active + h_front + h_sync + h_back;  // 24
    localparam int v_total      = v_active + v_front + v_sync + v_back;  // 12
    localparam int frame_cycles = h_total * v_total;
    localparam int cycle_limit  = 12 * frame_cycles + 200;
    localparam int mem_words    = h_active * v_active;

    logic                           clk_25_vga = 1'b0;
    logic                           rst_n_50m;
    logic [7:0]                     ir_code;
    logic                           ir_valid;
    logic [video_pkg::rgb565_w-1:0] pixel_data;
    logic [addr_w-1:0]              pixel_addr;
    logic [video_pkg::pixel_w-1:0]  vga_r;
    logic [video_pkg::pixel_w-1:0]  vga_g;
    logic [video_pkg::pixel_w-1:0]  vga_b;
    logic                           vga_hsync;
    logic                           vga_vsync;

    // frame buffer model
    logic [15:0] mem [mem_words];
    logic [15:0] fb_q [$];  // read latency line
    int          seed = 53;

    // reference model state
    control_pkg::display_mode_e m_mode;
    logic [7:0]                 m_thr;
    logic                       key_pending;
    logic [7:0]                 key_prev;
    int                         mx;
    int                         my;
    logic [18:0]                exp_q [$];  // {active, hsync, vsync, word}

    int pixel_errs  = 0;
    int sync_errs   = 0;
    int thr_errs    = 0;
    int addr_errs   = 0;
    int n_checks    = 0;
    int cycle_count = 0;

    logic [7:0] unknown_codes [6] = '{8'h00, 8'h02, 8'h10, 8'h1B, 8'h7F, 8'hFF};

    always #5 clk_25_vga = ~clk_25_vga;

    cam_display_top #(
        .h_active  (h_active),
        .h_front   (h_front),
        .h_sync    (h_sync),
        .h_back    (h_back),
        .v_active  (v_active),
        .v_front   (v_front),
        .v_sync    (v_sync),
        .v_back    (v_back),
        .addr_w    (addr_w),
        .mem_rd_lat(mem_rd_lat)
    ) cam_display_top_inst (
        .clk_25_vga(clk_25_vga),
        .rst_n_50m (rst_n_50m),
        .ir_code   (ir_code),
        .ir_valid  (ir_valid),
        .pixel_data(pixel_data),
        .pixel_addr(pixel_addr),
        .vga_r     (vga_r),
        .vga_g     (vga_g),
        .vga_b     (vga_b),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync)
    );

    `include "tb_checks.svh"

    // ========================================
    // per-cycle model and stimulus
    // ========================================
    task automatic run_cycle(input logic [7:0] code, input logic valid);
        control_pkg::display_mode_e mode_d;
        logic [7:0]                 thr_d;
        logic [18:0]                ent;
        logic                       act;
        logic                       hs;
        logic                       vs;
        logic [addr_w-1:0]          addr;
        mode_d = m_mode;  // mode seen by the output register
        thr_d  = m_thr;
        if (key_pending) apply_key(key_prev);
        ent = exp_q.pop_front();
        check_output(ent, mode_d, thr_d);
        // raw raster for this cycle
        act  = (mx < h_active) && (my < v_active);
        hs   = !((mx >= h_active + h_front) && (mx < h_active + h_front + h_sync));
        vs   = !((my >= v_active + v_front) && (my < v_active + v_front + v_sync));
        addr = act ? addr_w'(my * h_active + mx) : '0;
        check_addr(pixel_addr, addr);
        exp_q.push_back({act, hs, vs, mem[addr]});
        fb_q.push_back(mem[pixel_addr]);  // frame buffer answers the DUT address
        pixel_data  = fb_q.pop_front();
        ir_code     = code;
        ir_valid    = valid;
        key_pending = valid;
        key_prev    = code;
        if (mx == h_total - 1) begin
            mx = 0;
            my = (my == v_total - 1) ? 0 : my + 1;
        end else begin
            mx = mx + 1;
        end
        @(posedge clk_25_vga);
        #1;
    endtask

    task automatic press_key(input logic [7:0] code);
        run_cycle(code, 1'b1);
    endtask

    task automatic run_to_vblank();
        run_cycle(8'h00, 1'b0);
        while (mx != 0 || my != v_active) begin
            run_cycle(8'h00, 1'b0);
        end
    endtask

    // a burst of 20 to 35 random up/down presses
    task automatic press_random_adjust(input logic with_unknown);
        logic [31:0] rnd;
        int          count;
        rnd   = $random(seed);
        count = 20 + int'(rnd[3:0]);
        for (int i = 0; i < count; i++) begin
            rnd = $random(seed);
            if (with_unknown && rnd[2:1] == 2'b00) begin
                press_key(unknown_codes[int'(rnd[11:4]) % 6]);
            end else if (rnd[0]) begin
                press_key(control_pkg::key_up);
            end else begin
                press_key(control_pkg::key_down);
            end
        end
    endtask

    task automatic print_counts();
        $display("errors: pixel %0d, sync %0d, threshold %0d, address %0d in %0d checks",
                 pixel_errs, sync_errs, thr_errs, addr_errs, n_checks);
    endtask

    // hang guard
    always @(posedge clk_25_vga) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            print_counts();
            $display("Test failures found");
            $finish;
        end
    end

    // ========================================
    // test sequence
    // ========================================
    initial begin
        rst_n_50m   = 1'b0;
        ir_code     = 8'h00;
        ir_valid    = 1'b0;
        pixel_data  = '0;
        m_mode      = control_pkg::mode_orig;
        m_thr       = control_pkg::thr_reset;
        key_pending = 1'b0;
        key_prev    = 8'h00;
        mx          = 0;
        my          = 0;
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = 16'($random(seed));
        end
        repeat (mem_rd_lat) fb_q.push_back(16'h0000);
        // reset values still in the pipeline
        repeat (mem_rd_lat + 2) exp_q.push_back({1'b0, 1'b1, 1'b1, 16'h0000});
        repeat (16) @(posedge clk_25_vga);
        #1;
        rst_n_50m = 1'b1;

        run_to_vblank();  // frame 0 in colour
        press_key(control_pkg::key_gray);
        run_to_vblank();
        press_key(control_pkg::key_thresh);
        run_to_vblank();  // threshold at 64
        repeat (60) press_key(control_pkg::key_up);  // runs past 255
        run_to_vblank();
        repeat (60) press_key(control_pkg::key_down);  // runs past 0
        run_to_vblank();
        press_random_adjust(1'b0);
        run_to_vblank();
        press_random_adjust(1'b1);
        run_to_vblank();  // unknown codes must keep the threshold
        press_key(control_pkg::key_red);
        run_to_vblank();
        for (int i = 0; i < 6; i++) begin
            press_key(unknown_codes[i]);  // mask must stay
        end
        run_to_vblank();
        press_key(control_pkg::key_orig);
        run_to_vblank();
        repeat (mem_rd_lat + 2) run_cycle(8'h00, 1'b0);

        print_counts();
        if (pixel_errs + sync_errs + thr_errs + addr_errs == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+tb
src/video_pkg.sv
src/control_pkg.sv
src/mode_controller.sv
src/raster_counter.sv
src/pixel_convert.sv
src/display_mux.sv
src/cam_display_top.sv
tb/tb_cam_display.sv

// ==== Makefile ====
# Verilator simulation of the VGA display path

TOP := tb_cam_display

.PHONY: sim clean

sim:
	verilator --binary --timing -j 0 --top-module $(TOP) -f sim.f -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -q 'All tests passed!'

clean:
	rm -rf obj_dir
